// ==== source/coherencePkg.sv ====
// shared types and constants for the dual-core coherence bus, imported by each design file
`default_nettype none

package coherencePkg;

  // two cores share one bus and one memory
  localparam int CORES = 2;

  // main memory size in words, indexed by word address bits
  localparam int RAM_DEPTH = 256;
  localparam int RAM_ADDR_W = $clog2(RAM_DEPTH);

  // cycles spent in RAM_BUSY before the access completes
  localparam int RAM_LATENCY = 2;
  localparam int LAT_W = $clog2(RAM_LATENCY + 1);

  typedef logic [31:0] word_t;

  typedef enum logic [1:0] {
    RAM_FREE,
    RAM_BUSY,
    RAM_ACCESS
  } ramState_t;

  // one cache's side of the bus, instruction and data port together
  typedef struct packed {
    logic  iREN;
    logic  dREN;
    logic  dWEN;
    logic  cctrans;
    logic  ccwrite;
    word_t iaddr;
    word_t daddr;
    word_t dstore;
  } cacheReq_t;

  typedef struct packed {
    logic  iwait;
    logic  dwait;
    logic  ccwait;
    logic  ccinv;
    word_t iload;
    word_t dload;
    word_t ccsnoopaddr;
  } cacheRsp_t;

  typedef struct packed {
    logic  ramREN;
    logic  ramWEN;
    word_t ramaddr;
    word_t ramstore;
  } ramReq_t;

  typedef struct packed {
    ramState_t ramState;
    word_t     ramload;
  } ramRsp_t;

  // arbiter decision, held until the controller signals done
  typedef struct packed {
    logic valid;
    logic core;
    logic isData;
    logic isWrite;
  } grant_t;

endpackage

`default_nettype wire

// ==== source/ramModel.sv ====
// word-addressed main memory with fixed latency, sitting behind the coherence controller
`default_nettype none
`timescale 1ns/100ps

module ramModel
  import coherencePkg::*;
(
  input  logic    CLK,
  input  logic    arstN,
  input  ramReq_t ramReq,
  output ramRsp_t ramRsp
);

  word_t            mem [RAM_DEPTH];
  ramState_t        state;
  logic [LAT_W-1:0] count;
  word_t            capAddr;
  word_t            capData;
  logic             capWrite;
  logic             access;
  logic             start;

  assign access = ramReq.ramREN | ramReq.ramWEN;

  // new access, or the address moved while counting
  assign start = access && (state == RAM_FREE ||
                            (state == RAM_BUSY && ramReq.ramaddr != capAddr));

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state <= RAM_FREE;
      count <= '0;
    end else begin
      case (state)
        RAM_FREE: begin
          if (access) begin
            state <= RAM_BUSY;
            count <= '0;
          end
        end
        RAM_BUSY: begin
          if (start) begin
            count <= '0;
          end else if (count == LAT_W'(RAM_LATENCY - 1)) begin
            state <= RAM_ACCESS;
          end else begin
            count <= count + 1'b1;
          end
        end
        default: state <= RAM_FREE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      capAddr  <= ramReq.ramaddr;
      capData  <= ramReq.ramstore;
      capWrite <= ramReq.ramWEN;
    end
    if (state == RAM_ACCESS && capWrite) begin
      mem[capAddr[RAM_ADDR_W+1:2]] <= capData;
    end
  end

  assign ramRsp.ramState = state;
  assign ramRsp.ramload  = mem[capAddr[RAM_ADDR_W+1:2]];

endmodule

`default_nettype wire

// ==== source/busArbiter.sv ====
// picks one of the four request sources for the coherence controller, data before instruction
`default_nettype none
`timescale 1ns/100ps

module busArbiter
  import coherencePkg::*;
(
  input  logic      CLK,
  input  logic      arstN,
  input  cacheReq_t cacheReq [CORES],
  input  logic      done,
  output grant_t    grant
);

  logic [CORES-1:0] dataReq;
  logic [CORES-1:0] instReq;
  logic             lastData;
  logic             lastInst;
  grant_t           pick;

  // with both cores asking, the one not served last wins
  function automatic logic pickCore(input logic [CORES-1:0] req, input logic last);
    if (&req) begin
      return ~last;
    end
    return req[1];
  endfunction

  always_comb begin
    for (int c = 0; c < CORES; c++) begin
      dataReq[c] = cacheReq[c].dREN | cacheReq[c].dWEN;
      instReq[c] = cacheReq[c].iREN;
    end
  end

  always_comb begin
    pick = '0;
    if (|dataReq) begin
      pick.valid   = 1'b1;
      pick.isData  = 1'b1;
      pick.core    = pickCore(dataReq, lastData);
      pick.isWrite = cacheReq[pick.core].dWEN;
    end else if (|instReq) begin
      pick.valid = 1'b1;
      pick.core  = pickCore(instReq, lastInst);
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      grant    <= '0;
      lastData <= 1'b0;
      lastInst <= 1'b0;
    end else if (grant.valid) begin
      // hold until the transfer ends
      if (done) begin
        grant.valid <= 1'b0;
      end
    end else if (pick.valid) begin
      grant <= pick;
      if (pick.isData) begin
        lastData <= pick.core;
      end else begin
        lastInst <= pick.core;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/coherenceControl.sv ====
// serves the granted request, snoops the other core and moves words between caches and memory
`default_nettype none
`timescale 1ns/100ps

module coherenceControl
  import coherencePkg::*;
(
  input  logic      CLK,
  input  logic      arstN,
  input  cacheReq_t cacheReq [CORES],
  input  grant_t    grant,
  input  ramRsp_t   ramRsp,
  output cacheRsp_t cacheRsp [CORES],
  output ramReq_t   ramReq,
  output logic      done
);

  typedef enum logic [2:0] {
    IDLE,
    SNOOP,
    ANSWER,
    RAMREAD,
    RAMWRITE,
    FWDWRITE,
    FINISH
  } ctrlState_t;

  ctrlState_t state;
  ctrlState_t nextState;
  logic       otherCore;
  logic       snoopHit;
  logic       ramDone;
  logic       ownReq;
  word_t      reqAddr;
  word_t      dataReg;

  assign otherCore = ~grant.core;
  // other core owns the word modified
  assign snoopHit  = cacheReq[otherCore].ccwrite;
  assign ramDone   = ramRsp.ramState == RAM_ACCESS;

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (grant.valid) begin
          if (!grant.isData) begin
            nextState = RAMREAD;
          end else if (grant.isWrite) begin
            nextState = RAMWRITE;
          end else begin
            nextState = SNOOP;
          end
        end
      end
      SNOOP: nextState = ANSWER;
      ANSWER: nextState = snoopHit ? FWDWRITE : RAMREAD;
      RAMREAD, RAMWRITE: begin
        if (ramDone) begin
          nextState = FINISH;
        end
      end
      // requester already released, only the memory update is left
      FWDWRITE: begin
        if (ramDone) begin
          nextState = IDLE;
        end
      end
      default: nextState = IDLE;
    endcase
  end

  // address and data of the transfer in flight
  always_ff @(posedge CLK) begin
    case (state)
      IDLE: begin
        if (grant.valid) begin
          reqAddr <= grant.isData ? cacheReq[grant.core].daddr : cacheReq[grant.core].iaddr;
          dataReg <= cacheReq[grant.core].dstore;
          ownReq  <= cacheReq[grant.core].cctrans & cacheReq[grant.core].ccwrite;
        end
      end
      ANSWER: begin
        if (snoopHit) begin
          dataReg <= cacheReq[otherCore].dstore;
        end
      end
      RAMREAD: begin
        if (ramDone) begin
          dataReg <= ramRsp.ramload;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    for (int c = 0; c < CORES; c++) begin
      cacheRsp[c].iwait       = 1'b1;
      cacheRsp[c].dwait       = 1'b1;
      cacheRsp[c].ccwait      = 1'b0;
      cacheRsp[c].ccinv       = 1'b0;
      cacheRsp[c].iload       = dataReg;
      cacheRsp[c].dload       = dataReg;
      cacheRsp[c].ccsnoopaddr = reqAddr;
    end
    done = 1'b0;
    case (state)
      SNOOP: cacheRsp[otherCore].ccwait = 1'b1;
      ANSWER: begin
        cacheRsp[otherCore].ccwait = 1'b1;
        cacheRsp[otherCore].ccinv  = ownReq;
        // cache to cache, memory gets the word afterwards
        if (snoopHit) begin
          cacheRsp[grant.core].dload = cacheReq[otherCore].dstore;
          cacheRsp[grant.core].dwait = 1'b0;
          done = 1'b1;
        end
      end
      FINISH: begin
        if (grant.isData) begin
          cacheRsp[grant.core].dwait = 1'b0;
        end else begin
          cacheRsp[grant.core].iwait = 1'b0;
        end
        done = 1'b1;
      end
      default: ;
    endcase
  end

  assign ramReq.ramREN   = state == RAMREAD;
  assign ramReq.ramWEN   = state == RAMWRITE || state == FWDWRITE;
  assign ramReq.ramaddr  = reqAddr;
  assign ramReq.ramstore = dataReg;

endmodule

`default_nettype wire

// ==== source/memorySystem.sv ====
// top level of the dual-core memory system, joins both caches to the controller and memory
`default_nettype none
`timescale 1ns/100ps

module memorySystem
  import coherencePkg::*;
(
  input  logic      CLK,
  input  logic      arstN,
  input  cacheReq_t cacheReq [CORES],
  output cacheRsp_t cacheRsp [CORES]
);

  grant_t  grant;
  logic    done;
  ramReq_t ramReq;
  ramRsp_t ramRsp;

  busArbiter arb0 (
    .CLK      (CLK),
    .arstN    (arstN),
    .cacheReq (cacheReq),
    .done     (done),
    .grant    (grant)
  );

  coherenceControl ctrl0 (
    .CLK      (CLK),
    .arstN    (arstN),
    .cacheReq (cacheReq),
    .grant    (grant),
    .ramRsp   (ramRsp),
    .cacheRsp (cacheRsp),
    .ramReq   (ramReq),
    .done     (done)
  );

  ramModel ram0 (
    .CLK    (CLK),
    .arstN  (arstN),
    .ramReq (ramReq),
    .ramRsp (ramRsp)
  );

endmodule

`default_nettype wire

// ==== verif/memorySystem_assert.sv ====
// protocol assertions on the coherence controller outputs, bound into coherenceControl
`default_nettype none
`timescale 1ns/100ps

module memorySystem_assert
  import coherencePkg::*;
(
  input logic      CLK,
  input logic      arstN,
  input cacheRsp_t cacheRsp [CORES],
  input grant_t    grant
);

  // read by the testbench summary
  int failCount = 0;

  // only one core is snooped at a time
  snoopOneCore: assert property (@(posedge CLK) disable iff (!arstN)
    !(cacheRsp[0].ccwait && cacheRsp[1].ccwait))
    else begin
      $error("ccwait high to both cores");
      failCount++;
    end

  for (genvar c = 0; c < CORES; c++) begin : perCore
    invOneCycle: assert property (@(posedge CLK) disable iff (!arstN)
      cacheRsp[c].ccinv |=> !cacheRsp[c].ccinv)
      else begin
        $error("ccinv to core %0d lasted more than one cycle", c);
        failCount++;
      end

    // a released wait belongs to the granted transfer
    waitUnderGrant: assert property (@(posedge CLK) disable iff (!arstN)
      (!cacheRsp[c].dwait || !cacheRsp[c].iwait) |-> grant.valid)
      else begin
        $error("wait to core %0d fell without a valid grant", c);
        failCount++;
      end
  end

endmodule

bind coherenceControl memorySystem_assert chk0 (
  .CLK      (CLK),
  .arstN    (arstN),
  .cacheRsp (cacheRsp),
  .grant    (grant)
);

`default_nettype wire

// ==== verif/memorySystemTb.sv ====
// testbench for the dual-core memory system, models both MSI caches and checks every load
`default_nettype none
`timescale 1ns/100ps

module memorySystemTb
  import coherencePkg::*;
();

  typedef enum logic [1:0] {INV, SHR, MOD} msi_t;
  typedef enum logic [1:0] {OP_NONE, OP_SHR, OP_OWN, OP_WB} dataOp_t;

  logic      CLK;
  logic      arstN;
  cacheReq_t req [CORES];
  cacheRsp_t rsp [CORES];

  // cache models and reference memory
  msi_t    st [CORES][RAM_DEPTH];
  word_t   wd [CORES][RAM_DEPTH];
  word_t   refMem [RAM_DEPTH];

  // outstanding requests per core
  dataOp_t dOp [CORES];
  int      dIdx [CORES];
  word_t   dData [CORES];
  logic    iPend [CORES];
  int      iIdx [CORES];

  word_t   lastDLoad [CORES];
  word_t   lastILoad [CORES];
  int      dDoneAt [CORES];
  int      iDoneAt [CORES];
  int      doneSeq;
  logic    invSeen [CORES];
  word_t   invAddr [CORES];
  int      checkCount;
  int      errCount;
  int      errAtStart;
  // fill, directed and random transfers
  int      txnTotal = 64 + 4 + 3 + 1 + 4 + 200;

  memorySystem dut0 (
    .CLK      (CLK),
    .arstN    (arstN),
    .cacheReq (req),
    .cacheRsp (rsp)
  );

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  function automatic word_t addrOf(input int idx);
    return word_t'(idx) << 2;
  endfunction

  function automatic word_t fillWord(input int idx);
    word_t a;
    a = addrOf(idx);
    return (a * 32'h9e37) ^ {a[15:0], ~a[15:0]};
  endfunction

  // a modified copy in either cache wins over memory, the instruction port reads memory only
  function automatic word_t refLoad(input int idx, input logic isInst);
    if (!isInst) begin
      for (int c = 0; c < CORES; c++) begin
        if (st[c][idx] == MOD) begin
          return wd[c][idx];
        end
      end
    end
    return refMem[idx];
  endfunction

  function automatic logic busy();
    return dOp[0] != OP_NONE || dOp[1] != OP_NONE || iPend[0] || iPend[1];
  endfunction

  // requests from the pending state, snoop answers from the model copies
  task automatic driveInputs();
    int sIdx;
    for (int c = 0; c < CORES; c++) begin
      sIdx = rsp[c].ccsnoopaddr[RAM_ADDR_W+1:2];
      req[c].iREN    = iPend[c];
      req[c].iaddr   = addrOf(iIdx[c]);
      req[c].dREN    = dOp[c] == OP_SHR || dOp[c] == OP_OWN;
      req[c].dWEN    = dOp[c] == OP_WB;
      req[c].cctrans = dOp[c] == OP_SHR || dOp[c] == OP_OWN;
      req[c].daddr   = addrOf(dIdx[c]);
      if (rsp[c].ccwait) begin
        req[c].ccwrite = st[c][sIdx] == MOD;
        req[c].dstore  = wd[c][sIdx];
      end else begin
        req[c].ccwrite = dOp[c] == OP_OWN;
        req[c].dstore  = dData[c];
      end
    end
  endtask

  task automatic runUntilIdle();
    driveInputs();
    while (busy()) begin
      @(negedge CLK);
      driveInputs();
    end
  endtask

  task automatic issueData(input int c, input dataOp_t op, input int idx, input word_t data);
    dOp[c]   = op;
    dIdx[c]  = idx;
    dData[c] = data;
  endtask

  task automatic issueInst(input int c, input int idx);
    iPend[c] = 1'b1;
    iIdx[c]  = idx;
  endtask

  // a core holding the word modified can only write it back
  task automatic issueRandomData(input int c);
    int idx;
    int r;
    idx = $urandom_range(15);
    r = $urandom_range(2);
    if (st[c][idx] == MOD) begin
      issueData(c, OP_WB, idx, wd[c][idx]);
    end else if (r == 0) begin
      issueData(c, OP_SHR, idx, $urandom());
    end else if (r == 1) begin
      issueData(c, OP_OWN, idx, $urandom());
    end else begin
      issueData(c, OP_WB, idx, $urandom());
    end
  endtask

  task automatic checkWord(input string what, input word_t got, input word_t exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      errCount++;
    end
  endtask

  task automatic reportTest(input string name);
    if (errCount == errAtStart) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errCount - errAtStart);
    end
    errAtStart = errCount;
  endtask

  // compare process, samples the values held through the cycle that just ended
  always @(posedge CLK) begin : compare
    int    idx;
    int    o;
    word_t expWord;
    if (arstN) begin
      for (int c = 0; c < CORES; c++) begin
        o = 1 - c;
        if (rsp[c].ccinv) begin
          invSeen[c] = 1'b1;
          invAddr[c] = rsp[c].ccsnoopaddr;
        end
        if (!rsp[c].dwait && dOp[c] == OP_NONE) begin
          $display("core %0d data wait fell at %0t without a request", c, $time);
          errCount++;
        end else if (!rsp[c].dwait) begin
          idx = dIdx[c];
          if (dOp[c] == OP_WB) begin
            refMem[idx] = dData[c];
            st[c][idx] = INV;
          end else begin
            expWord = refLoad(idx, 1'b0);
            lastDLoad[c] = rsp[c].dload;
            checkWord($sformatf("core %0d data load of word %0d", c, idx),
                      rsp[c].dload, expWord);
            // forwarded word also reaches memory
            if (st[o][idx] == MOD) begin
              refMem[idx] = wd[o][idx];
              st[o][idx] = SHR;
            end
            if (dOp[c] == OP_OWN) begin
              st[o][idx] = INV;
              st[c][idx] = MOD;
              wd[c][idx] = dData[c];
            end else begin
              st[c][idx] = SHR;
              wd[c][idx] = expWord;
            end
          end
          dOp[c] = OP_NONE;
          doneSeq++;
          dDoneAt[c] = doneSeq;
        end
        if (!rsp[c].iwait && !iPend[c]) begin
          $display("core %0d instruction wait fell at %0t without a request", c, $time);
          errCount++;
        end else if (!rsp[c].iwait) begin
          lastILoad[c] = rsp[c].iload;
          checkWord($sformatf("core %0d instruction load of word %0d", c, iIdx[c]),
                    rsp[c].iload, refLoad(iIdx[c], 1'b1));
          iPend[c] = 1'b0;
          doneSeq++;
          iDoneAt[c] = doneSeq;
        end
      end
    end
  end

  initial begin
    word_t newWord;
    int    issued;
    int    totalErr;
    void'($urandom(32'h10a520b8));
    arstN = 1'b0;
    doneSeq = 0;
    checkCount = 0;
    errCount = 0;
    errAtStart = 0;
    for (int c = 0; c < CORES; c++) begin
      req[c] = '0;
      dOp[c] = OP_NONE;
      dIdx[c] = 0;
      dData[c] = '0;
      iPend[c] = 1'b0;
      iIdx[c] = 0;
      invSeen[c] = 1'b0;
      for (int i = 0; i < RAM_DEPTH; i++) begin
        st[c][i] = INV;
        wd[c][i] = '0;
      end
    end
    for (int i = 0; i < RAM_DEPTH; i++) begin
      refMem[i] = '0;
    end
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    arstN = 1'b1;

    repeat (4) begin
      @(negedge CLK);
      for (int c = 0; c < CORES; c++) begin
        checkCount++;
        if (!rsp[c].iwait || !rsp[c].dwait || rsp[c].ccwait || rsp[c].ccinv) begin
          $display("FAILED at %0t: core %0d outputs not idle after reset", $time, c);
          errCount++;
        end
      end
    end
    reportTest("reset state");

    // memory contents for every word the tests touch
    for (int i = 0; i < 64; i++) begin
      issueData(0, OP_WB, i, fillWord(i));
      runUntilIdle();
    end

    newWord = $urandom();
    issueData(0, OP_WB, 20, newWord);
    runUntilIdle();
    issueData(1, OP_SHR, 20, '0);
    runUntilIdle();
    checkWord("core 1 read after core 0 write-back", lastDLoad[1], newWord);
    newWord = $urandom();
    issueData(1, OP_WB, 21, newWord);
    runUntilIdle();
    issueData(0, OP_SHR, 21, '0);
    runUntilIdle();
    checkWord("core 0 read after core 1 write-back", lastDLoad[0], newWord);
    reportTest("write-back then read");

    newWord = $urandom();
    issueData(0, OP_OWN, 30, newWord);
    runUntilIdle();
    issueData(1, OP_SHR, 30, '0);
    runUntilIdle();
    checkWord("forwarded modified word", lastDLoad[1], newWord);
    issueInst(1, 30);
    runUntilIdle();
    checkWord("instruction read after forward", lastILoad[1], newWord);
    reportTest("cache to cache forward");

    invSeen[0] = 1'b0;
    invSeen[1] = 1'b0;
    issueData(1, OP_OWN, 40, $urandom());
    runUntilIdle();
    checkCount++;
    if (!invSeen[0] || invSeen[1]) begin
      $display("ccinv did not reach core 0 alone on the ownership read");
      errCount++;
    end else begin
      checkWord("ccsnoopaddr with ccinv", invAddr[0], addrOf(40));
    end
    reportTest("ownership invalidate");

    issueData(0, OP_SHR, 50, '0);
    issueData(1, OP_SHR, 51, '0);
    issueInst(0, 52);
    issueInst(1, 53);
    runUntilIdle();
    checkCount++;
    if (dDoneAt[0] > iDoneAt[0] || dDoneAt[0] > iDoneAt[1] ||
        dDoneAt[1] > iDoneAt[0] || dDoneAt[1] > iDoneAt[1]) begin
      $display("an instruction read finished before a data read at %0t", $time);
      errCount++;
    end
    reportTest("simultaneous requests");

    issued = 0;
    while (issued < 200) begin
      @(negedge CLK);
      for (int c = 0; c < CORES; c++) begin
        if (dOp[c] == OP_NONE && issued < 200 && $urandom_range(2) == 0) begin
          issueRandomData(c);
          issued++;
        end
        if (!iPend[c] && issued < 200 && $urandom_range(3) == 0) begin
          issueInst(c, $urandom_range(15));
          issued++;
        end
      end
      driveInputs();
    end
    runUntilIdle();
    reportTest("random traffic");

    totalErr = errCount + dut0.ctrl0.chk0.failCount;
    $display("checks %0d, errors %0d, assertion failures %0d",
             checkCount, errCount, dut0.ctrl0.chk0.failCount);
    if (totalErr == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog, about 20 cycles per transfer
  initial begin
    repeat (3 + txnTotal * 20) @(posedge CLK);
    $display("timeout: a wait output never fell within %0d cycles", 3 + txnTotal * 20);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/coherencePkg.sv
source/ramModel.sv
source/busArbiter.sv
source/coherenceControl.sv
source/memorySystem.sv
verif/memorySystem_assert.sv
verif/memorySystemTb.sv
